// ==== sim.f ====
+incdir+logic
logic/riscv_pkg.sv
logic/riscv_ifu.sv
logic/riscv_regfile.sv
logic/riscv_decode.sv
logic/riscv_alu.sv
logic/riscv_mem_wb.sv
logic/riscv_core.sv
sim/riscv_checker.sv
sim/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/riscv_pkg.sv
      - logic/riscv_ifu.sv
      - logic/riscv_regfile.sv
      - logic/riscv_decode.sv
      - logic/riscv_alu.sv
      - logic/riscv_mem_wb.sv
      - logic/riscv_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/riscv_checker.sv
      - sim/tb_riscv_core.sv

// ==== sim/tb_riscv_core.sv ====
`timescale 1ns/10ps

module tb_riscv_core;

  localparam int MEM_WORDS      = 512;
  localparam int PROG_WORDS     = 64;
  localparam int TIMEOUT_CYCLES = PROG_WORDS * (2 * (4 + 4) + 4) + 100;

  logic        clk;
  logic        rst;
  logic        bus_req;
  logic        bus_write;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_ack;
  logic [31:0] bus_rdata;
  logic        retire_vld;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  logic [31:0] mem [MEM_WORDS];
  integer      seed;
  int          cycle_count;
  logic        run_done;
  int          errors_total;
  int          failed_tests;

  // Memory model request state
  logic        pending;
  int          wait_cycles;
  logic [31:0] req_addr;
  logic        req_write;
  logic [31:0] req_wdata;

  riscv_core dut (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_ack     (bus_ack),
    .bus_rdata   (bus_rdata),
    .retire_vld  (retire_vld),
    .retire_pc   (retire_pc),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  riscv_checker chk (
    .clk          (clk),
    .rst          (rst),
    .bus_req      (bus_req),
    .bus_write    (bus_write),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_ack      (bus_ack),
    .retire_vld   (retire_vld),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .image        (mem),
    .done         (run_done),
    .errors_total (errors_total),
    .failed_tests (failed_tests)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] itype_word(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd,
                                             logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] store_word(logic [11:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(logic [12:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [11:0] data_off;
    logic [2:0]  f3;
    int          kind;
    int          span;
    int          offset;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'hd47a_0000 ^ (i * 4);
    for (int i = 0; i < PROG_WORDS - 1; i++)
    begin
      kind     = $random(seed) & 15;
      r        = $random(seed);
      rd       = r[11:7];
      rs1      = r[19:15];
      rs2      = r[24:20];
      imm      = {{4{r[31]}}, r[31:24]};
      // Eight data words so that loads often hit earlier stores
      data_off = 12'h400 + {r[29:27], 2'b00};
      // Forward targets never pass the final self-jump
      span     = PROG_WORDS - 1 - i;
      offset   = 4 * (1 + (($random(seed) & 3) % span));
      case (kind)
        0, 1, 2, 3:
        begin
          case (r[6:5])
            2'd0: f3 = 3'b000;
            2'd1: f3 = 3'b100;
            2'd2: f3 = 3'b110;
            default: f3 = 3'b111;
          endcase
          mem[i] = itype_word(imm, rs1, f3, rd, 7'b0010011);
        end
        4, 5, 6:
        begin
          case (r[6:4])
            3'd0: mem[i] = rtype_word(7'b0000000, rs2, rs1, 3'b000, rd);
            3'd1: mem[i] = rtype_word(7'b0100000, rs2, rs1, 3'b000, rd);
            3'd2: mem[i] = rtype_word(7'b0000000, rs2, rs1, 3'b111, rd);
            3'd3: mem[i] = rtype_word(7'b0000000, rs2, rs1, 3'b110, rd);
            default: mem[i] = rtype_word(7'b0000000, rs2, rs1, 3'b100, rd);
          endcase
        end
        7: mem[i] = {r[31:12], rd, 7'b0110111};
        8, 9: mem[i] = itype_word(data_off, 5'd0, 3'b010, rd, 7'b0000011);
        10, 11: mem[i] = store_word(data_off, rs2, 5'd0);
        12, 13: mem[i] = branch_word(offset[12:0], rs2, rs1, {2'b00, r[0]});
        14: mem[i] = jal_word(offset[20:0], rd);
        // Custom-0 opcode outside RV32I
        default: mem[i] = {r[31:7], 7'b0001011};
      endcase
    end
    mem[PROG_WORDS - 1] = jal_word(21'd0, 5'd0);
  endtask

  task automatic answer_request();
    bus_ack   <= 1'b1;
    bus_rdata <= mem[req_addr[10:2]];
    if (req_write)
      mem[req_addr[10:2]] = req_wdata;
  endtask

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    bus_ack     = 1'b0;
    bus_rdata   = '0;
    pending     = 1'b0;
    wait_cycles = 0;
    cycle_count = 0;
    seed        = 32'hc6c5;
    build_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

  // Bus memory with 1 to 4 cycles of ack latency
  always @(posedge clk)
  begin
    bus_ack <= 1'b0;
    if (pending)
    begin
      if (wait_cycles == 0)
      begin
        answer_request();
        pending = 1'b0;
      end
      else
        wait_cycles = wait_cycles - 1;
    end
    if (!rst && bus_req)
    begin
      req_addr    = bus_addr;
      req_write   = bus_write;
      req_wdata   = bus_wdata;
      wait_cycles = $random(seed) & 3;
      if (wait_cycles == 0)
        answer_request();
      else
      begin
        pending     = 1'b1;
        wait_cycles = wait_cycles - 1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (run_done)
    begin
      $display("%0d tests, %0d failed, %0d mismatches in total", 6, failed_tests,
               errors_total);
      if (errors_total == 0)
        $display("No errors");
      else
        $display("Errors found");
      $finish;
    end
    else if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("program did not reach its final self-jump within %0d cycles",
               TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

endmodule

// ==== sim/riscv_checker.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_req,
  input  logic        bus_write,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_wdata,
  input  logic        bus_ack,
  input  logic        retire_vld,
  input  logic [31:0] retire_pc,
  input  logic [4:0]  retire_rd,
  input  logic [31:0] retire_data,
  input  logic [31:0] image [512],
  output logic        done,
  output int          errors_total,
  output int          failed_tests
);

  logic [31:0] model_mem [512];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  int          errors [1:6];
  logic [31:0] store_addr_q [$];
  logic [31:0] store_data_q [$];
  logic        in_reset;
  logic        first_req_seen;
  logic        outstanding;
  int          since_reset;
  int          cycle;
  int          req_cycle;
  int          lat_min;
  int          lat_max;
  int          failures;

  assign errors_total = errors[1] + errors[2] + errors[3] + errors[4] + errors[5] + errors[6];
  assign failed_tests = failures;

  initial
  begin
    done           = 1'b0;
    in_reset       = 1'b0;
    first_req_seen = 1'b0;
    outstanding    = 1'b0;
    since_reset    = 0;
    cycle          = 0;
    req_cycle      = 0;
    lat_min        = 1000;
    lat_max        = 0;
    failures       = 0;
    model_pc       = `RISCV_RESET_PC;
    for (int i = 1; i <= 6; i++)
      errors[i] = 0;
  end

  task automatic check_hex(input string name, input logic [31:0] exp,
                           input logic [31:0] act, input int behavior);
    if (act !== exp)
    begin
      $display("error %s: expected %h, got %h (model pc %h)", name, exp, act, model_pc);
      errors[behavior]++;
    end
  endtask

  task automatic report_failure(input string what, input int behavior);
    $display("%s", what);
    errors[behavior]++;
  endtask

  task automatic report_behavior(input string title, input int behavior);
    if (errors[behavior] == 0)
      $display("%s: pass", title);
    else
    begin
      $display("%s: fail, %0d mismatches", title, errors[behavior]);
      failures++;
    end
  endtask

  task automatic finish_report();
    if (store_addr_q.size() != 0)
      report_failure("bus writes left over with no SW retired for them", 3);
    report_behavior("arithmetic, immediates and LUI", 2);
    report_behavior("loads and stores", 3);
    report_behavior("control flow", 4);
    report_behavior("register zero and illegal encodings", 5);
    report_behavior($sformatf("random ack latency (%0d to %0d cycles)", lat_min, lat_max), 6);
    done <= 1'b1;
  endtask

  task automatic watch_bus();
    if (bus_ack && outstanding)
    begin
      if (cycle - req_cycle < lat_min)
        lat_min = cycle - req_cycle;
      if (cycle - req_cycle > lat_max)
        lat_max = cycle - req_cycle;
      outstanding = 1'b0;
    end
    if (bus_req)
    begin
      if (outstanding)
        report_failure("bus_req issued before the previous bus_ack", 6);
      if (!first_req_seen)
      begin
        first_req_seen = 1'b1;
        if (since_reset != 2)
          report_failure($sformatf("first bus_req came %0d cycles after reset instead of 2",
                                   since_reset), 1);
        check_hex("bus_addr", `RISCV_RESET_PC, bus_addr, 1);
        check_hex("bus_write", 32'd0, {31'd0, bus_write}, 1);
        report_behavior("reset and first fetch", 1);
      end
      if (bus_write)
      begin
        store_addr_q.push_back(bus_addr);
        store_data_q.push_back(bus_wdata);
      end
      outstanding = 1'b1;
      req_cycle   = cycle;
    end
  endtask

  // One model instruction per retire_vld
  task automatic retire_step();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic [4:0]  exp_rd;
    logic        writes;
    logic        legal;
    logic        is_store;
    int          behavior;
    inst     = model_mem[model_pc[10:2]];
    a        = model_regs[inst[19:15]];
    b        = model_regs[inst[24:20]];
    imm_i    = {{20{inst[31]}}, inst[31:20]};
    imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    addr     = '0;
    result   = '0;
    next_pc  = model_pc + 32'd4;
    writes   = 1'b0;
    legal    = 1'b1;
    is_store = 1'b0;
    behavior = 2;
    case (inst[6:0])
      7'b0110111:
      begin
        writes = 1'b1;
        result = {inst[31:12], 12'b0};
      end
      7'b0010011:
      begin
        writes = 1'b1;
        case (inst[14:12])
          3'b000: result = a + imm_i;
          3'b100: result = a ^ imm_i;
          3'b110: result = a | imm_i;
          3'b111: result = a & imm_i;
          default: legal = 1'b0;
        endcase
      end
      7'b0110011:
      begin
        writes = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: result = a + b;
          10'b0100000_000: result = a - b;
          10'b0000000_100: result = a ^ b;
          10'b0000000_110: result = a | b;
          10'b0000000_111: result = a & b;
          default: legal = 1'b0;
        endcase
      end
      7'b0000011:
      begin
        behavior = 3;
        writes   = 1'b1;
        legal    = (inst[14:12] == 3'b010);
        addr     = a + imm_i;
        result   = model_mem[addr[10:2]];
      end
      7'b0100011:
      begin
        behavior = 3;
        legal    = (inst[14:12] == 3'b010);
        is_store = legal;
        addr     = a + imm_s;
      end
      7'b1100011:
      begin
        behavior = 4;
        if (inst[14:12] == 3'b000)
        begin
          if (a == b)
            next_pc = model_pc + imm_b;
        end
        else if (inst[14:12] == 3'b001)
        begin
          if (a != b)
            next_pc = model_pc + imm_b;
        end
        else
          legal = 1'b0;
      end
      7'b1101111:
      begin
        behavior = 4;
        writes   = 1'b1;
        result   = model_pc + 32'd4;
        next_pc  = model_pc + imm_j;
      end
      default: legal = 1'b0;
    endcase
    if (!legal)
    begin
      writes   = 1'b0;
      behavior = 5;
    end
    if (writes && inst[11:7] == 5'd0)
      behavior = 5;
    exp_rd = (writes && inst[11:7] != 5'd0) ? inst[11:7] : 5'd0;
    check_hex("retire_pc", model_pc, retire_pc, 4);
    check_hex("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd}, behavior);
    if (exp_rd != 5'd0)
      check_hex("retire_data", result, retire_data, behavior);
    if (is_store)
    begin
      if (store_addr_q.size() == 0)
        report_failure("SW retired without a bus write", 3);
      else
      begin
        check_hex("bus_addr", addr, store_addr_q.pop_front(), 3);
        check_hex("bus_wdata", b, store_data_q.pop_front(), 3);
      end
      model_mem[addr[10:2]] = b;
    end
    else if (store_addr_q.size() != 0)
    begin
      report_failure("bus write seen for an instruction that is not SW", 3);
      store_addr_q.delete();
      store_data_q.delete();
    end
    if (exp_rd != 5'd0)
      model_regs[exp_rd] = result;
    if (inst[6:0] == 7'b1101111 && next_pc == model_pc)
      finish_report();
    model_pc = next_pc;
  endtask

  always @(negedge rst)
  begin
    for (int i = 0; i < 512; i++)
      model_mem[i] = image[i];
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    model_pc = `RISCV_RESET_PC;
  end

  always @(posedge clk)
  begin
    cycle++;
    if (rst)
    begin
      // Outputs are settled from the second reset edge on
      if (in_reset && (bus_req !== 1'b0 || retire_vld !== 1'b0))
        report_failure("bus_req or retire_vld went high during reset", 1);
      in_reset    = 1'b1;
      since_reset = 0;
    end
    else
    begin
      in_reset = 1'b0;
      since_reset++;
      watch_bus();
      if (retire_vld && !done)
        retire_step();
    end
  end

endmodule

// ==== logic/riscv_core.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_core
  import riscv_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  output logic                   bus_req,
  output logic                   bus_write,
  output logic [`RISCV_XLEN-1:0] bus_addr,
  output logic [`RISCV_XLEN-1:0] bus_wdata,
  input  logic                   bus_ack,
  input  logic [`RISCV_XLEN-1:0] bus_rdata,
  output logic                   retire_vld,
  output logic [`RISCV_XLEN-1:0] retire_pc,
  output logic [4:0]             retire_rd,
  output logic [`RISCV_XLEN-1:0] retire_data
);

  logic [`RISCV_XLEN-1:0] pc;
  logic                   ifu_bus_req;
  logic [`RISCV_XLEN-1:0] ifu_bus_addr;
  ifu_s                   ifu_out;
  logic [4:0]             rs1;
  logic [4:0]             rs2;
  logic [`RISCV_XLEN-1:0] rs1_val;
  logic [`RISCV_XLEN-1:0] rs2_val;
  logic                   dec_vld;
  opcode_e                dec_opcode;
  alu_op_e                dec_alu_op;
  logic [4:0]             dec_rd;
  logic [`RISCV_XLEN-1:0] dec_a;
  logic [`RISCV_XLEN-1:0] dec_b;
  logic [`RISCV_XLEN-1:0] dec_imm;
  logic [`RISCV_XLEN-1:0] dec_pc;
  logic                   alu_vld;
  logic                   alu_access_mem;
  logic                   alu_store;
  logic [`RISCV_XLEN-1:0] alu_result;
  logic [`RISCV_XLEN-1:0] alu_store_data;
  logic [4:0]             alu_rd;
  logic                   alu_wb_en;
  logic [`RISCV_XLEN-1:0] alu_pc;
  logic                   mem_done;
  logic                   wr_en;
  logic [4:0]             wr_idx;
  logic [`RISCV_XLEN-1:0] wr_data;

  riscv_ifu u_ifu (
    .clk            (clk),
    .rst            (rst),
    .pc             (pc),
    .alu_vld        (alu_vld),
    .alu_access_mem (alu_access_mem),
    .mem_done       (mem_done),
    .bus_ack        (bus_ack),
    .bus_rdata      (bus_rdata),
    .ifu_bus_req    (ifu_bus_req),
    .ifu_bus_addr   (ifu_bus_addr),
    .ifu_out        (ifu_out)
  );

  riscv_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  riscv_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .ifu_out    (ifu_out),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .dec_vld    (dec_vld),
    .dec_opcode (dec_opcode),
    .dec_alu_op (dec_alu_op),
    .dec_rd     (dec_rd),
    .dec_a      (dec_a),
    .dec_b      (dec_b),
    .dec_imm    (dec_imm),
    .dec_pc     (dec_pc)
  );

  riscv_alu u_alu (
    .clk            (clk),
    .rst            (rst),
    .dec_vld        (dec_vld),
    .dec_opcode     (dec_opcode),
    .dec_alu_op     (dec_alu_op),
    .dec_rd         (dec_rd),
    .dec_a          (dec_a),
    .dec_b          (dec_b),
    .dec_imm        (dec_imm),
    .dec_pc         (dec_pc),
    .pc             (pc),
    .alu_vld        (alu_vld),
    .alu_access_mem (alu_access_mem),
    .alu_store      (alu_store),
    .alu_result     (alu_result),
    .alu_store_data (alu_store_data),
    .alu_rd         (alu_rd),
    .alu_wb_en      (alu_wb_en),
    .alu_pc         (alu_pc)
  );

  riscv_mem_wb u_mem_wb (
    .clk            (clk),
    .rst            (rst),
    .alu_vld        (alu_vld),
    .alu_access_mem (alu_access_mem),
    .alu_store      (alu_store),
    .alu_result     (alu_result),
    .alu_store_data (alu_store_data),
    .alu_rd         (alu_rd),
    .alu_wb_en      (alu_wb_en),
    .alu_pc         (alu_pc),
    .ifu_bus_req    (ifu_bus_req),
    .ifu_bus_addr   (ifu_bus_addr),
    .bus_req        (bus_req),
    .bus_write      (bus_write),
    .bus_addr       (bus_addr),
    .bus_wdata      (bus_wdata),
    .bus_ack        (bus_ack),
    .bus_rdata      (bus_rdata),
    .mem_done       (mem_done),
    .wr_en          (wr_en),
    .wr_idx         (wr_idx),
    .wr_data        (wr_data),
    .retire_vld     (retire_vld),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

endmodule

// ==== logic/riscv_mem_wb.sv ====
`timescale 1ns/10ps

module riscv_mem_wb (
  input  logic        clk,
  input  logic        rst,
  input  logic        alu_vld,
  input  logic        alu_access_mem,
  input  logic        alu_store,
  input  logic [31:0] alu_result,
  input  logic [31:0] alu_store_data,
  input  logic [4:0]  alu_rd,
  input  logic        alu_wb_en,
  input  logic [31:0] alu_pc,
  input  logic        ifu_bus_req,
  input  logic [31:0] ifu_bus_addr,
  output logic        bus_req,
  output logic        bus_write,
  output logic [31:0] bus_addr,
  output logic [31:0] bus_wdata,
  input  logic        bus_ack,
  input  logic [31:0] bus_rdata,
  output logic        mem_done,
  output logic        wr_en,
  output logic [4:0]  wr_idx,
  output logic [31:0] wr_data,
  output logic        retire_vld,
  output logic [31:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data
);

  logic        busy;
  logic        mem_req;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        writes_reg;

  assign writes_reg = alu_wb_en && (alu_rd != 5'd0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      mem_req    <= 1'b0;
      mem_done   <= 1'b0;
      retire_vld <= 1'b0;
    end
    else
    begin
      mem_req    <= 1'b0;
      mem_done   <= 1'b0;
      retire_vld <= 1'b0;
      if (alu_vld && alu_access_mem)
      begin
        busy    <= 1'b1;
        mem_req <= 1'b1;
      end
      else if (alu_vld)
        retire_vld <= 1'b1;
      if (busy && bus_ack)
      begin
        busy       <= 1'b0;
        mem_done   <= 1'b1;
        retire_vld <= 1'b1;
      end
    end
  end

  // Request fields are zero outside the request cycle
  always_ff @(posedge clk)
  begin
    mem_write <= 1'b0;
    mem_addr  <= '0;
    mem_wdata <= '0;
    if (alu_vld && alu_access_mem)
    begin
      mem_write <= alu_store;
      mem_addr  <= alu_result;
      mem_wdata <= alu_store ? alu_store_data : '0;
    end
    if (alu_vld && !alu_access_mem)
    begin
      retire_pc   <= alu_pc;
      retire_rd   <= writes_reg ? alu_rd : 5'd0;
      retire_data <= writes_reg ? alu_result : '0;
    end
    if (busy && bus_ack)
    begin
      retire_pc   <= alu_pc;
      retire_rd   <= writes_reg ? alu_rd : 5'd0;
      retire_data <= writes_reg ? bus_rdata : '0;
    end
  end

  // Fetch owns the bus unless a load or store is pending
  assign bus_req   = busy ? mem_req   : ifu_bus_req;
  assign bus_write = busy ? mem_write : 1'b0;
  assign bus_addr  = busy ? mem_addr  : ifu_bus_addr;
  assign bus_wdata = busy ? mem_wdata : '0;

  assign wr_en   = retire_vld && (retire_rd != 5'd0);
  assign wr_idx  = retire_rd;
  assign wr_data = retire_data;

endmodule

// ==== logic/riscv_alu.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_alu
  import riscv_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dec_vld,
  input  opcode_e                dec_opcode,
  input  alu_op_e                dec_alu_op,
  input  logic [4:0]             dec_rd,
  input  logic [`RISCV_XLEN-1:0] dec_a,
  input  logic [`RISCV_XLEN-1:0] dec_b,
  input  logic [`RISCV_XLEN-1:0] dec_imm,
  input  logic [`RISCV_XLEN-1:0] dec_pc,
  output logic [`RISCV_XLEN-1:0] pc,
  output logic                   alu_vld,
  output logic                   alu_access_mem,
  output logic                   alu_store,
  output logic [`RISCV_XLEN-1:0] alu_result,
  output logic [`RISCV_XLEN-1:0] alu_store_data,
  output logic [4:0]             alu_rd,
  output logic                   alu_wb_en,
  output logic [`RISCV_XLEN-1:0] alu_pc
);

  logic [`RISCV_XLEN-1:0] op_result;
  logic [`RISCV_XLEN-1:0] result;
  logic [`RISCV_XLEN-1:0] next_pc;
  logic                   taken;
  logic                   wb_en;

  always_comb
  begin
    case (dec_alu_op)
      alu_sub:    op_result = dec_a - dec_b;
      alu_and:    op_result = dec_a & dec_b;
      alu_or:     op_result = dec_a | dec_b;
      alu_xor:    op_result = dec_a ^ dec_b;
      alu_pass_b: op_result = dec_b;
      default:    op_result = dec_a + dec_b;
    endcase
  end

  // Both compares yield zero on equal operands
  assign taken = (dec_alu_op == alu_sub) ? (op_result == '0) : (op_result != '0);

  always_comb
  begin
    result  = op_result;
    next_pc = dec_pc + 'd4;
    wb_en   = 1'b0;
    case (dec_opcode)
      op_lui, op_imm, op_reg: wb_en = 1'b1;
      op_load:
      begin
        result = dec_a + dec_imm;
        wb_en  = 1'b1;
      end
      op_store: result = dec_a + dec_imm;
      op_branch:
      begin
        if (taken)
          next_pc = dec_pc + dec_imm;
      end
      op_jal:
      begin
        result  = dec_pc + 'd4;
        next_pc = dec_pc + dec_imm;
        wb_en   = 1'b1;
      end
      default: wb_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc      <= `RISCV_RESET_PC;
      alu_vld <= 1'b0;
    end
    else
    begin
      alu_vld <= dec_vld;
      if (dec_vld)
        pc <= next_pc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (dec_vld)
    begin
      alu_access_mem <= (dec_opcode == op_load) || (dec_opcode == op_store);
      alu_store      <= (dec_opcode == op_store);
      alu_result     <= result;
      alu_store_data <= dec_b;
      alu_rd         <= dec_rd;
      alu_wb_en      <= wb_en;
      alu_pc         <= dec_pc;
    end
  end

endmodule

// ==== logic/riscv_decode.sv ====
`timescale 1ns/10ps

module riscv_decode
  import riscv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  ifu_s        ifu_out,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic        dec_vld,
  output opcode_e     dec_opcode,
  output alu_op_e     dec_alu_op,
  output logic [4:0]  dec_rd,
  output logic [31:0] dec_a,
  output logic [31:0] dec_b,
  output logic [31:0] dec_imm,
  output logic [31:0] dec_pc
);

  logic [31:0] inst;
  logic [2:0]  funct3;
  opcode_e     opcode;
  alu_op_e     alu_op;
  logic [31:0] imm;

  assign inst   = ifu_out.inst;
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  always_comb
  begin
    opcode = op_illegal;
    alu_op = alu_add;
    imm    = {{20{inst[31]}}, inst[31:20]};
    case (inst[6:0])
      7'b0110111:
      begin
        opcode = op_lui;
        alu_op = alu_pass_b;
        imm    = {inst[31:12], 12'b0};
      end
      7'b1101111:
      begin
        opcode = op_jal;
        imm    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b1100011:
      begin
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (funct3 == 3'b000)
        begin
          opcode = op_branch;
          alu_op = alu_sub;
        end
        else if (funct3 == 3'b001)
        begin
          opcode = op_branch;
          alu_op = alu_xor;
        end
      end
      7'b0000011:
      begin
        if (funct3 == 3'b010)
          opcode = op_load;
      end
      7'b0100011:
      begin
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        if (funct3 == 3'b010)
          opcode = op_store;
      end
      7'b0010011:
      begin
        case (funct3)
          3'b000: opcode = op_imm;
          3'b100:
          begin
            opcode = op_imm;
            alu_op = alu_xor;
          end
          3'b110:
          begin
            opcode = op_imm;
            alu_op = alu_or;
          end
          3'b111:
          begin
            opcode = op_imm;
            alu_op = alu_and;
          end
          default: opcode = op_illegal;
        endcase
      end
      7'b0110011:
      begin
        if (inst[31:25] == 7'b0000000)
        begin
          case (funct3)
            3'b000: opcode = op_reg;
            3'b100:
            begin
              opcode = op_reg;
              alu_op = alu_xor;
            end
            3'b110:
            begin
              opcode = op_reg;
              alu_op = alu_or;
            end
            3'b111:
            begin
              opcode = op_reg;
              alu_op = alu_and;
            end
            default: opcode = op_illegal;
          endcase
        end
        else if (inst[31:25] == 7'b0100000 && funct3 == 3'b000)
        begin
          opcode = op_reg;
          alu_op = alu_sub;
        end
      end
      default: opcode = op_illegal;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      dec_vld <= 1'b0;
    else
      dec_vld <= ifu_out.vld;
  end

  // Operands latched while the register file reads are fresh
  always_ff @(posedge clk)
  begin
    if (ifu_out.vld)
    begin
      dec_opcode <= opcode;
      dec_alu_op <= alu_op;
      dec_rd     <= inst[11:7];
      dec_a      <= rs1_val;
      dec_imm    <= imm;
      dec_pc     <= ifu_out.pc;
      if (opcode == op_imm || opcode == op_lui || opcode == op_load)
        dec_b <= imm;
      else
        dec_b <= rs2_val;
    end
  end

endmodule

// ==== logic/riscv_regfile.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  output logic [`RISCV_XLEN-1:0]  rs1_val,
  output logic [`RISCV_XLEN-1:0]  rs2_val,
  input  logic                    wr_en,
  input  logic [4:0]              wr_idx,
  input  logic [`RISCV_XLEN-1:0]  wr_data
);

  logic [`RISCV_XLEN-1:0] regs [`RISCV_NREGS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `RISCV_NREGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != 5'd0)
      regs[wr_idx] <= wr_data;
  end

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

endmodule

// ==== logic/riscv_ifu.sv ====
`timescale 1ns/10ps

module riscv_ifu
  import riscv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] pc,
  input  logic        alu_vld,
  input  logic        alu_access_mem,
  input  logic        mem_done,
  input  logic        bus_ack,
  input  logic [31:0] bus_rdata,
  output logic        ifu_bus_req,
  output logic [31:0] ifu_bus_addr,
  output ifu_s        ifu_out
);

  typedef enum logic {
    idle,
    req
  } fetch_state_e;

  fetch_state_e state;
  logic         init;
  logic         start;

  // High for one cycle once reset is released
  always_ff @(posedge clk)
  begin
    init <= rst;
  end

  assign start = init | (alu_vld & ~alu_access_mem) | mem_done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= idle;
      ifu_bus_req  <= 1'b0;
      ifu_bus_addr <= '0;
      ifu_out.vld  <= 1'b0;
    end
    else
    begin
      ifu_bus_req  <= 1'b0;
      ifu_bus_addr <= '0;
      ifu_out.vld  <= 1'b0;
      case (state)
        idle:
        begin
          if (start)
          begin
            state        <= req;
            ifu_bus_req  <= 1'b1;
            ifu_bus_addr <= pc;
          end
        end
        req:
        begin
          if (bus_ack)
          begin
            state       <= idle;
            ifu_out.vld <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // PC stays put until the instruction executes
  always_ff @(posedge clk)
  begin
    if (state == req && bus_ack)
    begin
      ifu_out.inst <= bus_rdata;
      ifu_out.pc   <= pc;
    end
  end

endmodule

// ==== logic/riscv_pkg.sv ====
package riscv_pkg;

  // Fetched instruction with the address it came from
  typedef struct packed {
    logic        vld;
    logic [31:0] inst;
    logic [31:0] pc;
  } ifu_s;

  // Instruction classes handled by the core
  typedef enum logic [2:0] {
    op_lui,
    op_jal,
    op_branch,
    op_load,
    op_store,
    op_imm,
    op_reg,
    op_illegal
  } opcode_e;

  // BEQ decodes to alu_sub and BNE to alu_xor
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_e;

endpackage

// ==== logic/riscv_defines.svh ====
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Data and address width
`define RISCV_XLEN 32

// Architectural register count
`define RISCV_NREGS 32

// First fetch address
`define RISCV_RESET_PC 32'h0000_0000

`endif
